// File: Makefile
# Verilator build, run, lint and clean for the audio path testbench

VERILATOR ?= verilator
TOP       ?= audio_dac_tb
FILELIST  ?= audio_dac.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the simulator prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: audio_dac.f
+incdir+hw
hw/audio_dac_pkg.sv
hw/sample_sync.sv
hw/linear_interp.sv
hw/sigma_delta_dac.sv
hw/audio_dac_top.sv
verification/clock_gen.sv
verification/audio_dac_assertions.sv
verification/audio_dac_tb.sv

// File: hw/audio_dac_pkg.sv
// ----------------------------------------
// audio path types
//  sample_t  signed pcm word
//  stereo_t  left/right pair
//  acc_u     interpolator accumulator, raw or split view
// ----------------------------------------

`include "audio_dac_settings.svh"

package audio_dac_pkg;

	typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;	// one channel word

	typedef struct packed {
		sample_t lch;	// left
		sample_t rch;	// right
	} stereo_t;

	// accumulator word, added as one signed value,
	// read back as sample part plus fraction
	typedef union packed {
		logic signed [`AUDIO_SAMPLE_W+`AUDIO_FRAC_W-1:0] raw;	// adder view
		struct packed {
			sample_t                  sample;	// upper bits, to modulator
			logic [`AUDIO_FRAC_W-1:0] frac;		// ramp fraction
		} fields;
	} acc_u;

endpackage

// File: hw/audio_dac_settings.svh
// ----------------------------------------
// audio path build-time settings
//  sample and fraction widths
//  load period counter width
//  request synchroniser depth
// ----------------------------------------

`ifndef AUDIO_DAC_SETTINGS_SVH
`define AUDIO_DAC_SETTINGS_SVH

`define AUDIO_SAMPLE_W    16	// one incoming pcm sample
`define AUDIO_FRAC_W      8	// interpolation fraction below sample
`define AUDIO_LOAD_BITS   7	// 2**7 = 128 cycle load period
`define AUDIO_SYNC_STAGES 2	// flops on the request toggle

`endif

// File: hw/audio_dac_top.sv
// ----------------------------------------
// audio_dac_top
//  sample sync, linear interpolator
//  and a sigma-delta output per channel
// ----------------------------------------

`timescale 1ns/1ps

module audio_dac_top (
	input  logic                   CLK25,		// system clock
	input  logic                   RESET_N,		// async reset, low
	input  logic                   sample_req,	// toggle per new pair
	input  audio_dac_pkg::sample_t sample_lch,	// left pcm in
	input  audio_dac_pkg::sample_t sample_rch,	// right pcm in
	output audio_dac_pkg::acc_u    dac_lch,		// left ramp value
	output audio_dac_pkg::acc_u    dac_rch,		// right ramp value
	output logic                   pwm_l,		// left bit stream
	output logic                   pwm_r		// right bit stream
);

	import audio_dac_pkg::*;

	stereo_t pair;			// captured pair
	logic    new_sample;	// capture strobe, internal only

	// ----------------------------------------
	// input side
	// ----------------------------------------
	sample_sync u_sync (
		.CLK25      (CLK25),
		.RESET_N    (RESET_N),
		.sample_req (sample_req),
		.sample_lch (sample_lch),
		.sample_rch (sample_rch),
		.pair       (pair),
		.new_sample (new_sample)
	);

	linear_interp u_interp (
		.CLK25   (CLK25),
		.RESET_N (RESET_N),
		.pair    (pair),
		.acc_l   (dac_lch),	// also top output
		.acc_r   (dac_rch)
	);

	// ----------------------------------------
	// output modulators
	// ----------------------------------------
	sigma_delta_dac u_dac_l (
		.CLK25   (CLK25),
		.RESET_N (RESET_N),
		.level   (dac_lch),
		.pwm     (pwm_l)
	);

	sigma_delta_dac u_dac_r (
		.CLK25   (CLK25),
		.RESET_N (RESET_N),
		.level   (dac_rch),
		.pwm     (pwm_r)
	);

endmodule

// File: hw/linear_interp.sv
// ----------------------------------------
// linear_interp
//  free running load counter and load pulse
//  two channel first-order hold
//  accumulator ramps old to new sample
//  over one load period
// ----------------------------------------

`timescale 1ns/1ps

`include "audio_dac_settings.svh"

module linear_interp (
	input  logic                   CLK25,	// system clock
	input  logic                   RESET_N,	// async reset, low
	input  audio_dac_pkg::stereo_t pair,	// latest captured pair
	output audio_dac_pkg::acc_u    acc_l,	// left ramp
	output audio_dac_pkg::acc_u    acc_r	// right ramp
);

	import audio_dac_pkg::*;

	localparam int CH     = 2;	// 0 left, 1 right
	localparam int SMP_W  = `AUDIO_SAMPLE_W;
	localparam int FRAC_W = `AUDIO_FRAC_W;
	localparam int ACC_W  = SMP_W + FRAC_W;

	logic [`AUDIO_LOAD_BITS-1:0] load_cnt;	// period counter
	logic                        load;		// high while load_cnt == 1

	sample_t                 in_smp [CH];	// pair split per channel
	sample_t                 data0 [CH];	// newest loaded sample
	sample_t                 data1 [CH];	// previous sample
	sample_t                 diff [CH];		// data0 - data1, wraps
	acc_u                    acc [CH];		// ramp accumulator
	logic signed [ACC_W-1:0] step [CH];		// 2*diff, sign extended

	assign in_smp[0] = pair.lch;
	assign in_smp[1] = pair.rch;

	assign acc_l = acc[0];
	assign acc_r = acc[1];

	// ----------------------------------------
	// load timing
	// ----------------------------------------
	always_ff @(posedge CLK25 or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			load_cnt <= '0;
			load     <= 1'b0;
		end
		else
		begin
			load_cnt <= load_cnt + 1'b1;	// wraps every period
			load     <= (load_cnt == '0);	// registered, lands on count 1
		end
	end

	// per-edge increment: diff spread over 128 steps of 2**8 fraction
	always_comb
	begin
		for (int i = 0; i < CH; i++)
		begin
			step[i] = {{(FRAC_W-1){diff[i][SMP_W-1]}}, diff[i], 1'b0};
		end
	end

	// ----------------------------------------
	// interpolator datapath
	// ----------------------------------------
	always_ff @(posedge CLK25 or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			for (int i = 0; i < CH; i++)
			begin
				data0[i]   <= '0;
				data1[i]   <= '0;
				diff[i]    <= '0;
				acc[i].raw <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < CH; i++)
			begin
				if (load)
				begin
					data0[i]             <= in_smp[i];	// only pair held now
					data1[i]             <= data0[i];
					diff[i]              <= data0[i] - data1[i];	// 16 bit wrap
					acc[i].fields.sample <= data1[i];	// restart ramp
					acc[i].fields.frac   <= '0;
				end
				else
				begin
					acc[i].raw <= acc[i].raw + step[i];	// walk toward data0
				end
			end
		end
	end

endmodule

// File: hw/sample_sync.sv
// ----------------------------------------
// sample_sync
//  request toggle synchroniser
//  either-edge detect, one-cycle pulse
//  stereo pair capture register
// ----------------------------------------

`timescale 1ns/1ps

`include "audio_dac_settings.svh"

module sample_sync (
	input  logic                   CLK25,		// system clock
	input  logic                   RESET_N,		// async reset, low
	input  logic                   sample_req,	// toggles once per new pair
	input  audio_dac_pkg::sample_t sample_lch,	// left data, held by source
	input  audio_dac_pkg::sample_t sample_rch,	// right data, held by source
	output audio_dac_pkg::stereo_t pair,		// captured pair
	output logic                   new_sample	// one cycle per toggle
);

	localparam int STAGES = `AUDIO_SYNC_STAGES;

	logic [STAGES-1:0] req_sync;	// [0] first flop
	logic              req_last;	// previous synced level

	// ----------------------------------------
	// sync and edge detect
	// ----------------------------------------
	always_ff @(posedge CLK25 or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			req_sync   <= '0;
			req_last   <= 1'b0;
			new_sample <= 1'b0;
		end
		else
		begin
			req_sync   <= {req_sync[STAGES-2:0], sample_req};	// shift in
			req_last   <= req_sync[STAGES-1];
			new_sample <= req_sync[STAGES-1] ^ req_last;	// both polarities
		end
	end

	// ----------------------------------------
	// capture, data is stable by now
	// ----------------------------------------
	always_ff @(posedge CLK25 or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			pair <= '0;	// silence until first sample
		end
		else if (new_sample)
		begin
			pair.lch <= sample_lch;
			pair.rch <= sample_rch;
		end
	end

endmodule

// File: hw/sigma_delta_dac.sv
// ----------------------------------------
// sigma_delta_dac
//  first order modulator, one channel
//  offset binary of the sample field
//  carry out as the 1-bit stream
// ----------------------------------------

`timescale 1ns/1ps

`include "audio_dac_settings.svh"

module sigma_delta_dac (
	input  logic                CLK25,		// system clock
	input  logic                RESET_N,	// async reset, low
	input  audio_dac_pkg::acc_u level,		// interpolated value
	output logic                pwm			// bit stream out
);

	localparam int W = `AUDIO_SAMPLE_W;

	logic [W-1:0] offset_val;	// 0 .. 65535
	logic [W-1:0] sd_acc;		// error accumulator
	logic [W:0]   sum;			// msb is the carry

	// flip sign bit, -32768 maps to 0
	assign offset_val = {~level.fields.sample[W-1], level.fields.sample[W-2:0]};
	assign sum        = {1'b0, sd_acc} + {1'b0, offset_val};

	// ----------------------------------------
	// modulator
	// ----------------------------------------
	always_ff @(posedge CLK25 or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			sd_acc <= '0;
			pwm    <= 1'b0;
		end
		else
		begin
			sd_acc <= sum[W-1:0];	// keep the residue
			pwm    <= sum[W];		// ones density = offset_val / 2**W
		end
	end

endmodule

// File: verification/audio_dac_assertions.sv
// ----------------------------------------
// audio_dac_assertions
//  load pulse width and period
//  new_sample pulse width
//  pwm outputs low during reset
// ----------------------------------------

`timescale 1ns/1ps

`include "audio_dac_settings.svh"

module audio_dac_assertions (
	input logic CLK25,
	input logic RESET_N,
	input logic load,		// interpolator load pulse
	input logic new_sample,	// sync capture strobe
	input logic pwm_l,
	input logic pwm_r
);

	localparam int PERIOD = 1 << `AUDIO_LOAD_BITS;	// 128 cycles

	int fail_count = 0;	// failed assertion tally

	a_load_width : assert property (@(posedge CLK25) disable iff (!RESET_N)
		load |=> !load)
		else
		begin
			fail_count++;
			$error("load pulse longer than one cycle");
		end

	a_load_period : assert property (@(posedge CLK25) disable iff (!RESET_N)
		$past(load, PERIOD) |-> load)
		else
		begin
			fail_count++;
			$error("load pulse missing one period after the last");
		end

	a_new_width : assert property (@(posedge CLK25) disable iff (!RESET_N)
		new_sample |=> !new_sample)
		else
		begin
			fail_count++;
			$error("new_sample longer than one cycle");
		end

	a_pwm_reset : assert property (@(posedge CLK25)
		!RESET_N |-> (!pwm_l && !pwm_r))
		else
		begin
			fail_count++;
			$error("pwm output high during reset");
		end

endmodule

// top level sees the sync strobe, the pwm bits and the interpolator
bind audio_dac_top audio_dac_assertions u_assert (
	.CLK25      (CLK25),
	.RESET_N    (RESET_N),
	.load       (u_interp.load),
	.new_sample (new_sample),
	.pwm_l      (pwm_l),
	.pwm_r      (pwm_r)
);

// File: verification/audio_dac_stim.txt
// left right hold_cycles, hex, one request toggle per line
// hold of 0x380 or more also runs the pwm density count
1000 f000 0090
7fff 8000 0090
8000 7fff 0100
1234 0000 000a
4321 c000 0100
0c00 f400 0400
8000 7fff 0400
0111 0222 000c
0333 0444 0200

// File: verification/audio_dac_tb.sv
// ----------------------------------------
// audio_dac_tb
//  stim file driver, one toggle per line
//  cycle model of sync, interpolator, modulators
//  per-cycle compare, pwm density, watchdog
// ----------------------------------------

`timescale 1ns/1ps

`include "audio_dac_settings.svh"

module audio_dac_tb;

	import audio_dac_pkg::*;

	localparam int MAX_LINES = 64;
	localparam int PERIOD    = 1 << `AUDIO_LOAD_BITS;
	localparam int DENS_HOLD = 3 * PERIOD + 512;	// settle, then count

	logic    CLK25;
	logic    RESET_N;
	logic    sample_req;
	sample_t sample_lch;
	sample_t sample_rch;
	acc_u    dac_lch;
	acc_u    dac_rch;
	logic    pwm_l;
	logic    pwm_r;

	logic [15:0] stim [MAX_LINES*3];	// left, right, hold
	string       test_name = "reset";
	longint      watch_ns = 0;

	// reference model, index 0 left, 1 right
	logic               m_req0, m_req1, m_last, m_new;	// sync chain
	sample_t            m_cap [2];
	int                 m_cnt;
	logic               m_load;
	sample_t            m_d0 [2];
	sample_t            m_d1 [2];
	sample_t            m_df [2];
	logic signed [23:0] m_acc [2];
	logic [15:0]        m_sd [2];
	logic               m_pwm [2];

	clock_gen u_clk (.CLK25(CLK25), .RESET_N(RESET_N));

	audio_dac_top UUT (
		.CLK25 (CLK25), .RESET_N (RESET_N), .sample_req (sample_req),
		.sample_lch (sample_lch), .sample_rch (sample_rch),
		.dac_lch (dac_lch), .dac_rch (dac_rch), .pwm_l (pwm_l), .pwm_r (pwm_r)
	);

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic check_acc(input string name, input acc_u exp, input acc_u act);
		if (act !== exp)
		begin
			$display("FAIL %s expected %h actual %h", name, exp.raw, act.raw);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("FAIL %s expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_density(input string name, input sample_t level, input int ones);
		real expected;
		expected = real'(int'(level) + 32768) * 512.0 / 65536.0;
		if ((ones - expected) > 1.0 || (expected - ones) > 1.0)
		begin
			$display("FAIL %s expected %0.2f actual %0d", name, expected, ones);
			stop_run();
		end
	endtask

	// ----------------------------------------
	// reference model, consumers before producers
	// ----------------------------------------
	task automatic model_reset();
		{m_req0, m_req1, m_last, m_new, m_load} = '0;
		m_cnt = 0;
		for (int i = 0; i < 2; i++)
		begin
			m_cap[i] = '0;
			m_d0[i]  = '0;
			m_d1[i]  = '0;
			m_df[i]  = '0;
			m_acc[i] = '0;
			m_sd[i]  = '0;
			m_pwm[i] = 1'b0;
		end
	endtask

	task automatic model_step();
		int sum;
		for (int i = 0; i < 2; i++)
		begin
			sum      = int'(m_sd[i]) + int'(sample_t'(m_acc[i][23:8])) + 32768;
			m_pwm[i] = (sum >= 65536);	// carry of the 16 bit add
			m_sd[i]  = sum[15:0];
			if (m_load)
			begin
				m_acc[i] = {m_d1[i], 8'h00};	// ramp restarts at older sample
				m_df[i]  = m_d0[i] - m_d1[i];
				m_d1[i]  = m_d0[i];
				m_d0[i]  = m_cap[i];
			end
			else
			begin
				m_acc[i] = m_acc[i] + 24'(2 * int'(m_df[i]));
			end
		end
		m_load = (m_cnt == 0);
		m_cnt  = (m_cnt + 1) % PERIOD;
		if (m_new)
		begin
			m_cap[0] = sample_lch;
			m_cap[1] = sample_rch;
		end
		m_new  = m_req1 ^ m_last;	// either edge
		m_last = m_req1;
		m_req1 = m_req0;
		m_req0 = sample_req;
	endtask

	always @(posedge CLK25)
	begin
		if (!RESET_N)
			model_reset();
		else
			model_step();
	end

	// outputs settled half a cycle after the edge
	always @(negedge CLK25)
	begin
		acc_u exp_l;
		acc_u exp_r;
		exp_l.raw = m_acc[0];
		exp_r.raw = m_acc[1];
		check_acc({test_name, " dac_lch"}, exp_l, dac_lch);
		check_acc({test_name, " dac_rch"}, exp_r, dac_rch);
		check_bit({test_name, " pwm_l"}, m_pwm[0], pwm_l);
		check_bit({test_name, " pwm_r"}, m_pwm[1], pwm_r);
	end

	// three periods bring a constant level, then 512 counted cycles
	task automatic measure_density(input int hold);
		int ones_l;
		int ones_r;
		ones_l = 0;
		ones_r = 0;
		repeat (3 * PERIOD) @(posedge CLK25);
		repeat (512)
		begin
			@(negedge CLK25);
			ones_l += int'(pwm_l);
			ones_r += int'(pwm_r);
		end
		check_density({test_name, " pwm_l ones"}, sample_lch, ones_l);
		check_density({test_name, " pwm_r ones"}, sample_rch, ones_r);
		repeat (hold - DENS_HOLD) @(posedge CLK25);
	endtask

	initial
	begin
		wait (watch_ns != 0);
		#(watch_ns);
		$display("watchdog expired before the stimulus finished");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial
	begin
		int n_lines;
		int hold_sum;
		int hold;
		sample_req = 1'b0;
		sample_lch = '0;
		sample_rch = '0;
		model_reset();
		for (int i = 0; i < MAX_LINES * 3; i++)
			stim[i] = '0;	// zero hold ends the list
		$readmemh("verification/audio_dac_stim.txt", stim);
		n_lines  = 0;
		hold_sum = 0;
		while (n_lines < MAX_LINES && stim[n_lines*3+2] != 16'h0)
		begin
			hold_sum += int'(stim[n_lines*3+2]);
			n_lines++;
		end
		if (n_lines == 0)
		begin
			$display("no stimulus lines found in the stim file");
			$display("TEST FAILED");
			$fatal(1, "empty stimulus");
		end
		watch_ns = longint'(hold_sum + 1024) * 10;
		wait (RESET_N === 1'b1);
		@(posedge CLK25);
		#1;
		for (int n = 0; n < n_lines; n++)
		begin
			test_name  = $sformatf("stim line %0d", n + 1);
			hold       = int'(stim[n*3+2]);
			sample_req = ~sample_req;	// one edge per pair
			sample_lch = sample_t'(stim[n*3]);
			sample_rch = sample_t'(stim[n*3+1]);
			if (hold >= DENS_HOLD)
				measure_density(hold);
			else
				repeat (hold) @(posedge CLK25);
			#1;
		end
		// bound checker keeps its own failure tally
		if (UUT.u_assert.fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: verification/clock_gen.sv
// ----------------------------------------
// clock_gen
//  10 ns CLK25, RESET_N low 16 cycles
// ----------------------------------------

`timescale 1ns/1ps

module clock_gen (
	output logic CLK25,		// 100 MHz sim clock
	output logic RESET_N	// released after 16 edges
);

	initial
	begin
		CLK25 = 1'b0;
		forever #5 CLK25 = ~CLK25;	// 10 ns period
	end

	initial
	begin
		RESET_N = 1'b0;
		repeat (16) @(posedge CLK25);
		#2 RESET_N = 1'b1;	// clear of the edge
	end

endmodule
